//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_arp
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hw/arp_pkg.sv
hw/arp_ifaces.sv
hw/arp_config_regs.sv
hw/arp_cache.sv
hw/arp_retry_timer.sv
hw/arp_resolver.sv
hw/arp_frame_handler.sv
hw/arp_top.sv
tests/arp_checker.sv
tests/arp_assertions.sv
tests/tb_arp.sv

//--- hw/arp_cache.sv
// direct-mapped ARP cache
`timescale 1ns/100ps

module arp_cache #(
    parameter int CACHE_ADDR_WIDTH = 4
) (
    input  logic          clk,
    input  logic          rst,
    arp_query_if.responder query,
    input  logic          cache_write,
    input  arp_pkg::ip_t  write_ip,
    input  arp_pkg::mac_t write_mac,
    arp_cfg_if.user       cfg
);

    localparam int DEPTH = 2 ** CACHE_ADDR_WIDTH;

    arp_pkg::ip_t  tag_mem [DEPTH];
    arp_pkg::mac_t mac_mem [DEPTH];
    logic [DEPTH-1:0] valid_bits;

    logic [CACHE_ADDR_WIDTH-1:0] query_idx;
    logic [CACHE_ADDR_WIDTH-1:0] write_idx;

    // low IP bits pick the entry, the full IP is the tag
    assign query_idx = query.query_ip[CACHE_ADDR_WIDTH-1:0];
    assign write_idx = write_ip[CACHE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (cache_write) begin
            tag_mem[write_idx] <= write_ip;
            mac_mem[write_idx] <= write_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cfg.clear_cache) begin
            valid_bits <= '0;
        end else if (cache_write) begin
            valid_bits[write_idx] <= 1'b1;
        end
    end

    // registered read, one cycle behind the query
    always_ff @(posedge clk) begin
        if (rst) begin
            query.resp_valid <= 1'b0;
        end else begin
            query.resp_valid <= query.query_valid;
        end
        query.resp_hit <= valid_bits[query_idx] && (tag_mem[query_idx] == query.query_ip);
        query.resp_mac <= mac_mem[query_idx];
    end

endmodule

//--- hw/arp_config_regs.sv
// ARP configuration registers
`timescale 1ns/100ps

module arp_config_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_write,
    input  arp_pkg::cfg_addr_t  cfg_addr,
    input  logic [31:0]         cfg_data,
    arp_cfg_if.source           cfg
);

    logic [31:0]  mac_lo;
    logic [15:0]  mac_hi;
    arp_pkg::ip_t local_ip;
    arp_pkg::ip_t gateway_ip;
    arp_pkg::ip_t subnet_mask;
    logic         clear_pulse;

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_lo      <= '0;
            mac_hi      <= '0;
            local_ip    <= '0;
            gateway_ip  <= '0;
            subnet_mask <= '0;
            clear_pulse <= 1'b0;
        end else begin
            // single cycle unless the clear write repeats
            clear_pulse <= cfg_write && (cfg_addr == arp_pkg::CFG_CLEAR_CACHE);
            if (cfg_write) begin
                case (cfg_addr)
                    arp_pkg::CFG_MAC_LO:      mac_lo      <= cfg_data;
                    arp_pkg::CFG_MAC_HI:      mac_hi      <= cfg_data[15:0];
                    arp_pkg::CFG_LOCAL_IP:    local_ip    <= cfg_data;
                    arp_pkg::CFG_GATEWAY_IP:  gateway_ip  <= cfg_data;
                    arp_pkg::CFG_SUBNET_MASK: subnet_mask <= cfg_data;
                    default: ;
                endcase
            end
        end
    end

    assign cfg.local_mac   = {mac_hi, mac_lo};
    assign cfg.local_ip    = local_ip;
    assign cfg.gateway_ip  = gateway_ip;
    assign cfg.subnet_mask = subnet_mask;
    assign cfg.clear_cache = clear_pulse;

endmodule

//--- hw/arp_frame_handler.sv
// ARP frame decode and outgoing frame slot
`timescale 1ns/100ps

module arp_frame_handler (
    input  logic          clk,
    input  logic          rst,
    input  logic          rx_valid,
    output logic          rx_ready,
    input  arp_pkg::mac_t rx_eth_src_mac,
    input  logic [15:0]   rx_eth_type,
    input  logic [15:0]   rx_htype,
    input  logic [15:0]   rx_ptype,
    input  arp_pkg::oper_t rx_oper,
    input  arp_pkg::mac_t rx_sha,
    input  arp_pkg::ip_t  rx_spa,
    input  arp_pkg::ip_t  rx_tpa,
    output logic          tx_valid,
    input  logic          tx_ready,
    output arp_pkg::mac_t tx_dest_mac,
    output arp_pkg::oper_t tx_oper,
    output arp_pkg::mac_t tx_tha,
    output arp_pkg::ip_t  tx_tpa,
    arp_cfg_if.user       cfg,
    output logic          cache_write,
    output arp_pkg::ip_t  write_ip,
    output arp_pkg::mac_t write_mac,
    input  logic          send_request,
    input  arp_pkg::ip_t  send_ip
);

    logic send_pending;
    logic rx_fire;
    logic rx_is_arp;

    // a waiting request owns the slot ahead of any reply
    assign rx_ready  = !tx_valid && !send_pending && !send_request;
    assign rx_fire   = rx_valid && rx_ready;
    assign rx_is_arp = (rx_eth_type == arp_pkg::ETH_TYPE_ARP) &&
                       (rx_htype == arp_pkg::HTYPE_ETHERNET) &&
                       (rx_ptype == arp_pkg::PTYPE_IPV4);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid     <= 1'b0;
            send_pending <= 1'b0;
            cache_write  <= 1'b0;
        end else begin
            cache_write <= rx_fire && rx_is_arp;
            if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (!tx_valid && (send_request || send_pending)) begin
                // broadcast who-has for the resolver
                tx_valid     <= 1'b1;
                tx_dest_mac  <= arp_pkg::MAC_BROADCAST;
                tx_oper      <= arp_pkg::OPER_REQUEST;
                tx_tha       <= arp_pkg::MAC_ZERO;
                tx_tpa       <= send_ip;
                send_pending <= 1'b0;
            end else if (send_request) begin
                send_pending <= 1'b1;
            end else if (rx_fire && rx_is_arp && rx_oper == arp_pkg::OPER_REQUEST &&
                         rx_tpa == cfg.local_ip) begin
                tx_valid    <= 1'b1;
                tx_dest_mac <= rx_eth_src_mac;
                tx_oper     <= arp_pkg::OPER_REPLY;
                tx_tha      <= rx_sha;
                tx_tpa      <= rx_spa;
            end
        end
        // sender pair goes to the cache
        write_ip  <= rx_spa;
        write_mac <= rx_sha;
    end

endmodule

//--- hw/arp_ifaces.sv
// ARP configuration and cache query interfaces
`timescale 1ns/100ps

interface arp_cfg_if;
    arp_pkg::mac_t local_mac;
    arp_pkg::ip_t  local_ip;
    arp_pkg::ip_t  gateway_ip;
    arp_pkg::ip_t  subnet_mask;
    logic          clear_cache;

    modport source (output local_mac, local_ip, gateway_ip, subnet_mask, clear_cache);
    modport user   (input  local_mac, local_ip, gateway_ip, subnet_mask, clear_cache);
endinterface

// response follows each query cycle by exactly one cycle
interface arp_query_if;
    logic          query_valid;
    arp_pkg::ip_t  query_ip;
    logic          resp_valid;
    logic          resp_hit;
    arp_pkg::mac_t resp_mac;

    modport requester (output query_valid, query_ip,
                       input  resp_valid, resp_hit, resp_mac);
    modport responder (input  query_valid, query_ip,
                       output resp_valid, resp_hit, resp_mac);
endinterface

//--- hw/arp_pkg.sv
// ARP resolver shared definitions
package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] oper_t;
    typedef logic [2:0]  cfg_addr_t;

    // frame header constants
    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] HTYPE_ETHERNET = 16'h0001;
    localparam logic [15:0] PTYPE_IPV4     = 16'h0800;

    localparam oper_t OPER_REQUEST = 16'd1;
    localparam oper_t OPER_REPLY   = 16'd2;

    localparam mac_t MAC_BROADCAST = 48'hffff_ffff_ffff;
    localparam mac_t MAC_ZERO      = 48'h0000_0000_0000;
    localparam ip_t  IP_BROADCAST  = 32'hffff_ffff;

    // configuration register map
    localparam cfg_addr_t CFG_MAC_LO      = 3'd0;
    localparam cfg_addr_t CFG_MAC_HI      = 3'd1;
    localparam cfg_addr_t CFG_LOCAL_IP    = 3'd2;
    localparam cfg_addr_t CFG_GATEWAY_IP  = 3'd3;
    localparam cfg_addr_t CFG_SUBNET_MASK = 3'd4;
    // write-only, data ignored
    localparam cfg_addr_t CFG_CLEAR_CACHE = 3'd5;

endpackage

//--- hw/arp_resolver.sv
// ARP lookup request state machine
`timescale 1ns/100ps

module arp_resolver #(
    parameter int RETRY_COUNT       = 4,
    parameter int RETRY_INTERVAL_MS = 2000,
    parameter int TIMEOUT_MS        = 30000,
    localparam int MS_WIDTH         = $clog2(TIMEOUT_MS + 1)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  arp_pkg::ip_t        req_ip,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic                resp_error,
    output arp_pkg::mac_t       resp_mac,
    arp_cfg_if.user             cfg,
    arp_query_if.requester      query,
    output logic                send_request,
    output arp_pkg::ip_t        send_ip,
    output logic                timer_load,
    output logic [MS_WIDTH-1:0] timer_load_ms,
    input  logic                timer_expired
);

    localparam int RETRY_WIDTH = $clog2(RETRY_COUNT + 1);
    localparam logic [MS_WIDTH-1:0] INTERVAL_LOAD = MS_WIDTH'(RETRY_INTERVAL_MS);
    localparam logic [MS_WIDTH-1:0] TIMEOUT_LOAD  = MS_WIDTH'(TIMEOUT_MS);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_QUERY = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;
    localparam logic [1:0] S_RESP  = 2'd3;

    logic [1:0]             state;
    logic [RETRY_WIDTH-1:0] retries_left;
    arp_pkg::ip_t           target_ip;
    arp_pkg::ip_t           lookup_ip;
    logic                   is_broadcast;
    logic                   query_valid;

    // classify the incoming request
    always_comb begin
        lookup_ip    = req_ip;
        is_broadcast = (req_ip == arp_pkg::IP_BROADCAST);
        if (((req_ip ^ cfg.gateway_ip) & cfg.subnet_mask) == '0) begin
            // subnet broadcast has all host bits set
            if ((req_ip | cfg.subnet_mask) == arp_pkg::IP_BROADCAST) begin
                is_broadcast = 1'b1;
            end
        end else begin
            lookup_ip = cfg.gateway_ip;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_IDLE;
            req_ready    <= 1'b0;
            query_valid  <= 1'b0;
            send_request <= 1'b0;
            timer_load   <= 1'b0;
            retries_left <= '0;
        end else begin
            send_request <= 1'b0;
            timer_load   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_valid && req_ready) begin
                        req_ready <= 1'b0;
                        if (is_broadcast) begin
                            resp_mac   <= arp_pkg::MAC_BROADCAST;
                            resp_error <= 1'b0;
                            state      <= S_RESP;
                        end else begin
                            target_ip   <= lookup_ip;
                            query_valid <= 1'b1;
                            state       <= S_QUERY;
                        end
                    end else begin
                        req_ready <= 1'b1;
                    end
                end
                S_QUERY, S_WAIT: begin
                    if (query.resp_valid && query.resp_hit) begin
                        resp_mac    <= query.resp_mac;
                        resp_error  <= 1'b0;
                        query_valid <= 1'b0;
                        state       <= S_RESP;
                    end else if (state == S_QUERY && query.resp_valid) begin
                        // first miss, keep querying while frames go out
                        send_request  <= 1'b1;
                        timer_load    <= 1'b1;
                        timer_load_ms <= (RETRY_COUNT > 1) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                        retries_left  <= RETRY_WIDTH'(RETRY_COUNT - 1);
                        state         <= S_WAIT;
                    end else if (state == S_WAIT && timer_expired && !timer_load) begin
                        // expiry is stale while a load is still in flight
                        if (retries_left != '0) begin
                            send_request  <= 1'b1;
                            timer_load    <= 1'b1;
                            timer_load_ms <= (retries_left == 1) ? TIMEOUT_LOAD : INTERVAL_LOAD;
                            retries_left  <= retries_left - 1'b1;
                        end else begin
                            resp_mac    <= arp_pkg::MAC_ZERO;
                            resp_error  <= 1'b1;
                            query_valid <= 1'b0;
                            state       <= S_RESP;
                        end
                    end
                end
                default: begin
                    if (resp_ready) begin
                        req_ready <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
            endcase
        end
    end

    assign resp_valid     = (state == S_RESP);
    assign query.query_valid = query_valid;
    assign query.query_ip = target_ip;
    assign send_ip        = target_ip;

endmodule

//--- hw/arp_retry_timer.sv
// millisecond retry timer
`timescale 1ns/100ps

module arp_retry_timer #(
    parameter int TICKS_PER_MS = 125000,
    parameter int TIMEOUT_MS   = 30000,
    localparam int MS_WIDTH    = $clog2(TIMEOUT_MS + 1)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                timer_load,
    input  logic [MS_WIDTH-1:0] timer_load_ms,
    output logic                timer_expired
);

    localparam int PRE_WIDTH = $clog2(TICKS_PER_MS + 1);
    localparam logic [PRE_WIDTH-1:0] PRE_LAST = PRE_WIDTH'(TICKS_PER_MS - 1);

    logic [PRE_WIDTH-1:0] prescale;
    logic [MS_WIDTH-1:0]  ms_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            ms_count <= '0;
        end else if (timer_load) begin
            // reload also restarts the prescaler
            prescale <= '0;
            ms_count <= timer_load_ms;
        end else if (ms_count != '0) begin
            if (prescale == PRE_LAST) begin
                prescale <= '0;
                ms_count <= ms_count - 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    assign timer_expired = (ms_count == '0);

endmodule

//--- hw/arp_top.sv
// ARP resolver top level
`timescale 1ns/100ps

module arp_top #(
    parameter int CACHE_ADDR_WIDTH  = 4,
    parameter int RETRY_COUNT       = 4,
    parameter int RETRY_INTERVAL_MS = 2000,
    parameter int TIMEOUT_MS        = 30000,
    parameter int TICKS_PER_MS      = 125000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_write,
    input  arp_pkg::cfg_addr_t cfg_addr,
    input  logic [31:0]        cfg_data,
    input  logic               req_valid,
    output logic               req_ready,
    input  arp_pkg::ip_t       req_ip,
    output logic               resp_valid,
    input  logic               resp_ready,
    output logic               resp_error,
    output arp_pkg::mac_t      resp_mac,
    input  logic               rx_valid,
    output logic               rx_ready,
    input  arp_pkg::mac_t      rx_eth_src_mac,
    input  logic [15:0]        rx_eth_type,
    input  logic [15:0]        rx_htype,
    input  logic [15:0]        rx_ptype,
    input  arp_pkg::oper_t     rx_oper,
    input  arp_pkg::mac_t      rx_sha,
    input  arp_pkg::ip_t       rx_spa,
    input  arp_pkg::ip_t       rx_tpa,
    output logic               tx_valid,
    input  logic               tx_ready,
    output arp_pkg::mac_t      tx_dest_mac,
    output arp_pkg::oper_t     tx_oper,
    output arp_pkg::mac_t      tx_tha,
    output arp_pkg::ip_t       tx_tpa
);

    localparam int MS_WIDTH = $clog2(TIMEOUT_MS + 1);

    logic                cache_write;
    arp_pkg::ip_t        write_ip;
    arp_pkg::mac_t       write_mac;
    logic                send_request;
    arp_pkg::ip_t        send_ip;
    logic                timer_load;
    logic [MS_WIDTH-1:0] timer_load_ms;
    logic                timer_expired;

    arp_cfg_if   cfg_if ();
    arp_query_if query_if ();

    arp_config_regs i_config_regs (
        .clk(clk), .rst(rst), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
        .cfg_data(cfg_data), .cfg(cfg_if.source)
    );

    arp_cache #(.CACHE_ADDR_WIDTH(CACHE_ADDR_WIDTH)) i_cache (
        .clk(clk), .rst(rst), .query(query_if.responder), .cache_write(cache_write),
        .write_ip(write_ip), .write_mac(write_mac), .cfg(cfg_if.user)
    );

    arp_retry_timer #(.TICKS_PER_MS(TICKS_PER_MS), .TIMEOUT_MS(TIMEOUT_MS)) i_retry_timer (
        .clk(clk), .rst(rst), .timer_load(timer_load), .timer_load_ms(timer_load_ms),
        .timer_expired(timer_expired)
    );

    arp_resolver #(
        .RETRY_COUNT(RETRY_COUNT),
        .RETRY_INTERVAL_MS(RETRY_INTERVAL_MS),
        .TIMEOUT_MS(TIMEOUT_MS)
    ) i_resolver (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req_ip(req_ip),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_error(resp_error),
        .resp_mac(resp_mac), .cfg(cfg_if.user), .query(query_if.requester),
        .send_request(send_request), .send_ip(send_ip), .timer_load(timer_load),
        .timer_load_ms(timer_load_ms), .timer_expired(timer_expired)
    );

    arp_frame_handler i_frame_handler (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .rx_eth_src_mac(rx_eth_src_mac), .rx_eth_type(rx_eth_type), .rx_htype(rx_htype),
        .rx_ptype(rx_ptype), .rx_oper(rx_oper), .rx_sha(rx_sha), .rx_spa(rx_spa),
        .rx_tpa(rx_tpa), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .tx_dest_mac(tx_dest_mac), .tx_oper(tx_oper), .tx_tha(tx_tha), .tx_tpa(tx_tpa),
        .cfg(cfg_if.user), .cache_write(cache_write), .write_ip(write_ip),
        .write_mac(write_mac), .send_request(send_request), .send_ip(send_ip)
    );

endmodule

//--- tests/arp_assertions.sv
// ARP handshake assertions
`timescale 1ns/100ps

module arp_assertions (
    input logic           clk,
    input logic           rst,
    input logic           req_ready,
    input logic           resp_valid,
    input logic           resp_ready,
    input logic           resp_error,
    input arp_pkg::mac_t  resp_mac,
    input logic           tx_valid,
    input logic           tx_ready,
    input arp_pkg::mac_t  tx_dest_mac,
    input arp_pkg::oper_t tx_oper,
    input arp_pkg::mac_t  tx_tha,
    input arp_pkg::ip_t   tx_tpa
);

    // stalled frame keeps every field
    assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_dest_mac) && $stable(tx_oper) &&
                                 $stable(tx_tha) && $stable(tx_tpa))
        else $error("tx frame changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_mac) && $stable(resp_error))
        else $error("response dropped or changed before resp_ready");

    assert property (@(posedge clk) disable iff (rst) !(req_ready && resp_valid))
        else $error("req_ready high while a response is pending");

endmodule

bind arp_top arp_assertions i_arp_assertions (
    .clk(clk), .rst(rst), .req_ready(req_ready), .resp_valid(resp_valid),
    .resp_ready(resp_ready), .resp_error(resp_error), .resp_mac(resp_mac),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_dest_mac(tx_dest_mac),
    .tx_oper(tx_oper), .tx_tha(tx_tha), .tx_tpa(tx_tpa)
);

//--- tests/arp_checker.sv
// ARP response and frame checker
`timescale 1ns/100ps

module arp_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           resp_valid,
    input  logic           resp_ready,
    input  logic           resp_error,
    input  arp_pkg::mac_t  resp_mac,
    input  logic           rx_ready,
    input  logic           tx_valid,
    input  logic           tx_ready,
    input  arp_pkg::mac_t  tx_dest_mac,
    input  arp_pkg::oper_t tx_oper,
    input  arp_pkg::mac_t  tx_tha,
    input  arp_pkg::ip_t   tx_tpa,
    input  arp_pkg::mac_t  exp_mac,
    input  logic           exp_error,
    input  arp_pkg::ip_t   exp_tpa,
    input  arp_pkg::oper_t exp_oper,
    input  logic           row_done,
    input  logic [3:0]     exp_frames,
    output int             error_count
);

    int frame_count;

    task automatic check_field(input string name, input logic [47:0] got, input logic [47:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            frame_count = 0;
            error_count = 0;
        end else begin
            if (tx_valid && tx_ready) begin
                frame_count++;
                check_field("tx_oper", tx_oper, exp_oper);
                if (exp_oper == arp_pkg::OPER_REQUEST) begin
                    // who-has goes to everyone
                    check_field("tx_dest_mac", tx_dest_mac, arp_pkg::MAC_BROADCAST);
                    check_field("tx_tha", tx_tha, arp_pkg::MAC_ZERO);
                end else begin
                    check_field("tx_dest_mac", tx_dest_mac, exp_mac);
                    check_field("tx_tha", tx_tha, exp_mac);
                end
                check_field("tx_tpa", tx_tpa, exp_tpa);
            end
            if (resp_valid && resp_ready) begin
                check_field("resp_mac", resp_mac, exp_mac);
                check_field("resp_error", resp_error, exp_error);
            end
            if (tx_valid && rx_ready) begin
                $display("rx_ready was high while the frame slot was full at %0t", $time);
                error_count++;
            end
            if (row_done) begin
                check_field("frame_count", frame_count, exp_frames);
                frame_count = 0;
            end
        end
    end

endmodule

//--- tests/tb_arp.sv
// ARP resolver testbench
`timescale 1ns/100ps

module tb_arp;

    localparam logic [1:0] K_LOOKUP   = 2'd0;
    localparam logic [1:0] K_RX_LOCAL = 2'd1;
    localparam logic [1:0] K_RX_OTHER = 2'd2;
    localparam logic [1:0] K_CLEAR    = 2'd3;
    localparam int WAIT_LIMIT   = 50;
    localparam int LOOKUP_LIMIT = 300;
    localparam int NUM_ROWS     = 12;

    localparam arp_pkg::ip_t LOCAL_IP  = 32'h0a00_0005;
    localparam arp_pkg::ip_t GW_IP     = 32'h0a00_0001;
    localparam arp_pkg::ip_t OTHER_IP  = 32'h0a00_004d;
    localparam arp_pkg::ip_t SUBNET_BC = 32'h0a00_00ff;
    localparam arp_pkg::ip_t IP_A      = 32'h0a00_0021;
    localparam arp_pkg::ip_t IP_FAR    = 32'h0808_0808;
    localparam arp_pkg::ip_t IP_LOST   = 32'h0a00_0033;
    localparam arp_pkg::ip_t IP_B      = 32'h0a00_0042;
    localparam arp_pkg::ip_t IP_C      = 32'h0a00_0054;
    localparam arp_pkg::mac_t MAC_A    = 48'h0200_0000_0021;
    localparam arp_pkg::mac_t MAC_GW   = 48'h0200_0000_0001;
    localparam arp_pkg::mac_t MAC_B    = 48'h0200_0000_0042;
    localparam arp_pkg::mac_t MAC_C    = 48'h0200_0000_0054;

    typedef struct packed {
        logic [1:0]    kind;
        arp_pkg::ip_t  ip;
        arp_pkg::mac_t peer_mac;
        arp_pkg::mac_t exp_mac;
        logic          exp_error;
        logic [3:0]    exp_frames;
        arp_pkg::ip_t  exp_tpa;
        logic          hold_tx;
    } row_t;

    logic clk;
    logic rst;
    logic cfg_write;
    arp_pkg::cfg_addr_t cfg_addr;
    logic [31:0] cfg_data;
    logic req_valid, req_ready, resp_valid, resp_ready, resp_error;
    arp_pkg::ip_t req_ip;
    arp_pkg::mac_t resp_mac;
    logic rx_valid, rx_ready, tx_valid, tx_ready;
    arp_pkg::mac_t rx_eth_src_mac, rx_sha, tx_dest_mac, tx_tha;
    logic [15:0] rx_eth_type, rx_htype, rx_ptype;
    arp_pkg::oper_t rx_oper, tx_oper;
    arp_pkg::ip_t rx_spa, rx_tpa, tx_tpa;
    arp_pkg::mac_t exp_mac;
    logic exp_error;
    arp_pkg::ip_t exp_tpa;
    arp_pkg::oper_t exp_oper;
    logic row_done;
    logic [3:0] exp_frames;
    int checker_errors;
    int tb_errors;
    row_t rows [NUM_ROWS];
    row_t row;

    arp_top #(
        .CACHE_ADDR_WIDTH(3), .RETRY_COUNT(3), .RETRY_INTERVAL_MS(3),
        .TIMEOUT_MS(6), .TICKS_PER_MS(4)
    ) i_arp_top (
        .clk(clk), .rst(rst), .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .req_valid(req_valid), .req_ready(req_ready), .req_ip(req_ip),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_error(resp_error),
        .resp_mac(resp_mac), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .rx_eth_src_mac(rx_eth_src_mac), .rx_eth_type(rx_eth_type), .rx_htype(rx_htype),
        .rx_ptype(rx_ptype), .rx_oper(rx_oper), .rx_sha(rx_sha), .rx_spa(rx_spa),
        .rx_tpa(rx_tpa), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .tx_dest_mac(tx_dest_mac), .tx_oper(tx_oper), .tx_tha(tx_tha), .tx_tpa(tx_tpa)
    );

    arp_checker i_checker (
        .clk(clk), .rst(rst), .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp_error(resp_error), .resp_mac(resp_mac), .rx_ready(rx_ready),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_dest_mac(tx_dest_mac),
        .tx_oper(tx_oper), .tx_tha(tx_tha), .tx_tpa(tx_tpa), .exp_mac(exp_mac),
        .exp_error(exp_error), .exp_tpa(exp_tpa), .exp_oper(exp_oper), .row_done(row_done),
        .exp_frames(exp_frames), .error_count(checker_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // tasks start and end 1 ns after a rising edge
    task automatic write_cfg(input arp_pkg::cfg_addr_t addr, input logic [31:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(posedge clk);
        #1 cfg_write = 1'b0;
    endtask

    task automatic drive_frame(input arp_pkg::mac_t mac, input arp_pkg::oper_t oper,
                               input arp_pkg::ip_t spa, input arp_pkg::ip_t tpa);
        rx_eth_src_mac = mac;
        rx_eth_type    = arp_pkg::ETH_TYPE_ARP;
        rx_htype       = arp_pkg::HTYPE_ETHERNET;
        rx_ptype       = arp_pkg::PTYPE_IPV4;
        rx_oper        = oper;
        rx_sha         = mac;
        rx_spa         = spa;
        rx_tpa         = tpa;
        rx_valid       = 1'b1;
    endtask

    task automatic run_lookup(input arp_pkg::ip_t ip, input arp_pkg::mac_t peer,
                              input logic hold);
        int cycles;
        int held;
        int resp_held;
        logic answered;
        logic done;
        logic drop_rx;
        logic send_reply;
        arp_pkg::ip_t reply_ip;
        cycles = 0;
        held = 0;
        resp_held = 0;
        answered = 1'b0;
        done = 1'b0;
        tx_ready = !hold;
        resp_ready = !hold;
        req_valid = 1'b1;
        req_ip = ip;
        @(posedge clk);
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        #1 req_valid = 1'b0;
        if (cycles >= WAIT_LIMIT) begin
            $display("timeout waiting for req_ready at %0t", $time);
            tb_errors++;
        end
        cycles = 0;
        while (!done && cycles < LOOKUP_LIMIT) begin
            @(posedge clk);
            cycles++;
            drop_rx = rx_valid && rx_ready;
            send_reply = tx_valid && tx_ready && tx_oper == arp_pkg::OPER_REQUEST &&
                         peer != arp_pkg::MAC_ZERO && !answered;
            reply_ip = tx_tpa;
            if (tx_valid && !tx_ready)
                held++;
            if (resp_valid && !resp_ready)
                resp_held++;
            done = resp_valid && resp_ready;
            #1;
            if (drop_rx)
                rx_valid = 1'b0;
            if (send_reply) begin
                // fake responder answers the who-has
                answered = 1'b1;
                drive_frame(peer, arp_pkg::OPER_REPLY, reply_ip, LOCAL_IP);
            end
            if (held >= 5)
                tx_ready = 1'b1;
            if (resp_held >= 3)
                resp_ready = 1'b1;
        end
        if (!done) begin
            $display("timeout waiting for lookup response at %0t", $time);
            tb_errors++;
        end
        rx_valid = 1'b0;
        tx_ready = 1'b1;
        resp_ready = 1'b1;
    endtask

    task automatic run_incoming(input arp_pkg::ip_t spa, input arp_pkg::mac_t mac,
                                input arp_pkg::ip_t tpa, input logic expect_frame);
        int cycles;
        cycles = 0;
        drive_frame(mac, arp_pkg::OPER_REQUEST, spa, tpa);
        @(posedge clk);
        while (!rx_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        #1 rx_valid = 1'b0;
        if (cycles >= WAIT_LIMIT) begin
            $display("timeout waiting for rx_ready at %0t", $time);
            tb_errors++;
        end
        if (expect_frame) begin
            cycles = 0;
            @(posedge clk);
            while (!(tx_valid && tx_ready) && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (cycles >= WAIT_LIMIT) begin
                $display("timeout waiting for reply frame at %0t", $time);
                tb_errors++;
            end
        end
        // cache write lands one cycle later
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic end_row(input logic [3:0] frames);
        exp_frames = frames;
        row_done = 1'b1;
        @(posedge clk);
        #1 row_done = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        req_valid = 1'b0;
        req_ip = '0;
        resp_ready = 1'b1;
        tx_ready = 1'b1;
        drive_frame(arp_pkg::MAC_ZERO, '0, '0, '0);
        rx_valid = 1'b0;
        exp_mac = '0;
        exp_error = 1'b0;
        exp_tpa = '0;
        exp_oper = arp_pkg::OPER_REQUEST;
        row_done = 1'b0;
        exp_frames = '0;
        tb_errors = 0;

        // kind, ip, responder, exp mac, exp error, frames, exp tpa, hold tx
        rows[0]  = '{K_LOOKUP, arp_pkg::IP_BROADCAST, arp_pkg::MAC_ZERO,
                     arp_pkg::MAC_BROADCAST, 1'b0, 4'd0, 32'h0, 1'b0};
        rows[1]  = '{K_LOOKUP, SUBNET_BC, arp_pkg::MAC_ZERO,
                     arp_pkg::MAC_BROADCAST, 1'b0, 4'd0, 32'h0, 1'b0};
        rows[2]  = '{K_LOOKUP, IP_A, MAC_A, MAC_A, 1'b0, 4'd1, IP_A, 1'b0};
        rows[3]  = '{K_LOOKUP, IP_A, arp_pkg::MAC_ZERO, MAC_A, 1'b0, 4'd0, IP_A, 1'b0};
        rows[4]  = '{K_LOOKUP, IP_FAR, MAC_GW, MAC_GW, 1'b0, 4'd1, GW_IP, 1'b0};
        rows[5]  = '{K_LOOKUP, IP_LOST, arp_pkg::MAC_ZERO, arp_pkg::MAC_ZERO,
                     1'b1, 4'd3, IP_LOST, 1'b0};
        rows[6]  = '{K_RX_LOCAL, IP_B, MAC_B, MAC_B, 1'b0, 4'd1, IP_B, 1'b0};
        rows[7]  = '{K_LOOKUP, IP_B, arp_pkg::MAC_ZERO, MAC_B, 1'b0, 4'd0, IP_B, 1'b0};
        rows[8]  = '{K_RX_OTHER, IP_C, MAC_C, MAC_C, 1'b0, 4'd0, IP_C, 1'b0};
        rows[9]  = '{K_LOOKUP, IP_C, arp_pkg::MAC_ZERO, MAC_C, 1'b0, 4'd0, IP_C, 1'b0};
        rows[10] = '{K_CLEAR, 32'h0, arp_pkg::MAC_ZERO, arp_pkg::MAC_ZERO,
                     1'b0, 4'd0, 32'h0, 1'b0};
        rows[11] = '{K_LOOKUP, IP_C, MAC_C, MAC_C, 1'b0, 4'd1, IP_C, 1'b1};

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        write_cfg(arp_pkg::CFG_MAC_LO, 32'hbbcc_dd05);
        write_cfg(arp_pkg::CFG_MAC_HI, 32'h0000_02aa);
        write_cfg(arp_pkg::CFG_LOCAL_IP, LOCAL_IP);
        write_cfg(arp_pkg::CFG_GATEWAY_IP, GW_IP);
        write_cfg(arp_pkg::CFG_SUBNET_MASK, 32'hffff_ff00);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            exp_mac = row.exp_mac;
            exp_error = row.exp_error;
            exp_tpa = row.exp_tpa;
            // only a request aimed at the local IP is answered with a reply
            exp_oper = (row.kind == K_RX_LOCAL) ? arp_pkg::OPER_REPLY : arp_pkg::OPER_REQUEST;
            case (row.kind)
                K_LOOKUP:   run_lookup(row.ip, row.peer_mac, row.hold_tx);
                K_RX_LOCAL: run_incoming(row.ip, row.peer_mac, LOCAL_IP, row.exp_frames != 0);
                K_RX_OTHER: run_incoming(row.ip, row.peer_mac, OTHER_IP, row.exp_frames != 0);
                default: begin
                    write_cfg(arp_pkg::CFG_CLEAR_CACHE, 32'h0);
                    repeat (2) @(posedge clk);
                    #1;
                end
            endcase
            end_row(row.exp_frames);
        end

        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
